// ==== psx_loader_params.svh ====
// load bases, bus widths, framebuffer constants and line stride
`ifndef PSX_LOADER_PARAMS_SVH
`define PSX_LOADER_PARAMS_SVH

// ============================================================
// download and system RAM
// ============================================================

// byte address width of the download channel and the RAM port
`define PSX_ADDR_W 27
// one download word from the host
`define PSX_HALF_W 16
// one packed RAM word
`define PSX_WORD_W 32

// bios image lands at 2 MB
`define PSX_BIOS_BASE 27'h0200000
// executables land at 4 MB
`define PSX_EXE_BASE 27'h0400000

// ============================================================
// framebuffer in DDR
// ============================================================

`define PSX_FB_ORIGIN 32'h3000_0000
// one VRAM line, 1024 pixels of 2 bytes
`define PSX_FB_STRIDE 14'd2048
// bgr 1555, 16 bpp
`define PSX_FB_FMT_16 5'd12
// rgb 888, 24 bpp
`define PSX_FB_FMT_24 5'd5
// full VRAM viewer window
`define PSX_VRAM_W 12'd1024
`define PSX_VRAM_H 12'd512

`endif

// ==== psx_loader_pkg.sv ====
// package with the download-kind and RAM write handshake state enums
`default_nettype none

package psx_loader_pkg;

	// ============================================================
	// download kind, decoded from the host download index
	// ============================================================

	typedef enum logic [1:0] {
		// no download running
		DL_NONE = 2'd0,
		// index 0, bios image
		DL_BIOS = 2'd1,
		// index 1 to 254, executable
		DL_EXE  = 2'd2,
		// index 255, cheat codes, not loaded
		DL_CODE = 2'd3
	} dl_kind_e;

	// ============================================================
	// four-phase RAM write handshake
	// ============================================================

	typedef enum logic [1:0] {
		// waiting for a packed word
		WR_IDLE    = 2'd0,
		// req high, waiting for ack high
		WR_REQ     = 2'd1,
		// req low, waiting for ack low
		WR_RELEASE = 2'd2
	} wr_state_e;

endpackage

`default_nettype wire

// ==== mem_wr_if.sv ====
// interface for one packed RAM write from the word packer to the write port
`default_nettype none

`include "psx_loader_params.svh"

interface mem_wr_if;

	// one-cycle strobe, addr and data valid with it
	logic                   valid;
	// RAM byte address, already rebased
	logic [`PSX_ADDR_W-1:0] addr;
	// upper half in 31:16, lower half in 15:0
	logic [`PSX_WORD_W-1:0] data;
	// write port still in a handshake
	logic                   busy;

	// source side
	modport packer (
		output valid,
		output addr,
		output data,
		input  busy
	);

	// sink side
	modport port (
		input  valid,
		input  addr,
		input  data,
		output busy
	);

endinterface

`default_nettype wire

// ==== loader_ctrl.sv ====
// download control with index decode, write gating, exe load pulse and core reset
`default_nettype none

module loader_ctrl (
	input  wire                       clk_1x,
	input  wire                       rst_n,

	// host download channel
	input  wire                       ioctl_download,
	input  wire [7:0]                 ioctl_index,
	input  wire                       ioctl_wr,

	// to the word packer
	output psx_loader_pkg::dl_kind_e  kind,
	output logic                      half_wr,

	// to the core
	output logic                      load_exe,
	output logic                      exe_loaded,
	output logic                      core_reset
);

	// ============================================================
	// index decode
	// ============================================================

	// kind of the download on the inputs right now
	psx_loader_pkg::dl_kind_e kind_next;
	// kind one cycle late, for end detection
	psx_loader_pkg::dl_kind_e kind_d;

	always_comb begin
		kind_next = psx_loader_pkg::DL_NONE;
		if (ioctl_download) begin
			// 0 is bios, 255 is the cheat list, the rest are executables
			if (ioctl_index == 8'd0) begin
				kind_next = psx_loader_pkg::DL_BIOS;
			end else if (ioctl_index == 8'hff) begin
				kind_next = psx_loader_pkg::DL_CODE;
			end else begin
				kind_next = psx_loader_pkg::DL_EXE;
			end
		end
	end

	// ============================================================
	// write gating
	// ============================================================

	// only images that go to RAM reach the packer
	// cheat downloads are dropped here
	assign half_wr = ioctl_wr &
		((kind == psx_loader_pkg::DL_BIOS) | (kind == psx_loader_pkg::DL_EXE));

	// ============================================================
	// kind pipeline, load pulse, loaded flag, core reset
	// ============================================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			kind       <= psx_loader_pkg::DL_NONE;
			kind_d     <= psx_loader_pkg::DL_NONE;
			load_exe   <= 1'b0;
			exe_loaded <= 1'b0;
			// core held while the loader itself is in reset
			core_reset <= 1'b1;
		end else begin
			kind   <= kind_next;
			kind_d <= kind;

			// exe kind just dropped away
			// lands two cycles after ioctl_download falls
			load_exe <= (kind_d == psx_loader_pkg::DL_EXE) &&
				(kind != psx_loader_pkg::DL_EXE);

			// sticky until the next reset
			if (kind_next == psx_loader_pkg::DL_EXE) begin
				exe_loaded <= 1'b1;
			end

			// core stays in reset for any download
			core_reset <= ioctl_download;
		end
	end

endmodule

`default_nettype wire

// ==== word_packer.sv ====
// packs two 16-bit download halves into one 32-bit RAM word with its address
`default_nettype none

`include "psx_loader_params.svh"

module word_packer (
	input  wire                            clk_1x,
	input  wire                            rst_n,

	// from loader_ctrl
	input  psx_loader_pkg::dl_kind_e       kind,
	input  wire                            half_wr,

	// host download payload
	input  wire [`PSX_ADDR_W-1:0]          ioctl_addr,
	input  wire [`PSX_HALF_W-1:0]          ioctl_dout,

	// packed word out
	mem_wr_if.packer                       wr
);

	// lower half waiting for its partner
	logic [`PSX_HALF_W-1:0] lo_q;
	// rebased byte address of the word
	logic [`PSX_ADDR_W-1:0] addr_q;
	// completed word
	logic [`PSX_WORD_W-1:0] data_q;
	logic                   valid_q;

	// ioctl_addr bit 1 picks the half
	wire upper_wr = half_wr & ioctl_addr[1];
	wire lower_wr = half_wr & ~ioctl_addr[1];

	// load base per image kind
	wire [`PSX_ADDR_W-1:0] base =
		(kind == psx_loader_pkg::DL_BIOS) ? `PSX_BIOS_BASE : `PSX_EXE_BASE;

	// payload, no reset
	always_ff @(posedge clk_1x) begin
		if (lower_wr) begin
			lo_q   <= ioctl_dout;
			addr_q <= ioctl_addr + base;
		end
		if (upper_wr) begin
			data_q <= {ioctl_dout, lo_q};
		end
	end

	// strobe on the cycle after the upper half
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= upper_wr & ~wr.busy;
		end
	end

	assign wr.valid = valid_q;
	assign wr.addr  = addr_q;
	assign wr.data  = data_q;

endmodule

`default_nettype wire

// ==== mem_write_port.sv ====
// four-phase RAM write handshake and host wait flag
`default_nettype none

`include "psx_loader_params.svh"

module mem_write_port (
	input  wire                      clk_1x,
	input  wire                      rst_n,

	// packed word in
	mem_wr_if.port                   wr,

	// external RAM write channel
	output logic                     mem_req,
	input  wire                      mem_ack,
	output logic [`PSX_ADDR_W-1:0]   mem_addr,
	output logic [`PSX_WORD_W-1:0]   mem_data,

	// host throttle
	output logic                     ioctl_wait
);

	psx_loader_pkg::wr_state_e state;

	// ============================================================
	// handshake FSM
	// ============================================================

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			state <= psx_loader_pkg::WR_IDLE;
		end else begin
			case (state)
				psx_loader_pkg::WR_IDLE: begin
					if (wr.valid) state <= psx_loader_pkg::WR_REQ;
				end
				// hold req until the RAM takes the word
				psx_loader_pkg::WR_REQ: begin
					if (mem_ack) state <= psx_loader_pkg::WR_RELEASE;
				end
				// req is low, wait for ack to return low
				psx_loader_pkg::WR_RELEASE: begin
					if (!mem_ack) state <= psx_loader_pkg::WR_IDLE;
				end
				default: state <= psx_loader_pkg::WR_IDLE;
			endcase
		end
	end

	// address and data stay put for the whole handshake
	always_ff @(posedge clk_1x) begin
		if (wr.valid && (state == psx_loader_pkg::WR_IDLE)) begin
			mem_addr <= wr.addr;
			mem_data <= wr.data;
		end
	end

	// decoded from state, both rise together
	assign mem_req    = (state == psx_loader_pkg::WR_REQ);
	assign ioctl_wait = (state != psx_loader_pkg::WR_IDLE);
	assign wr.busy    = (state != psx_loader_pkg::WR_IDLE);

endmodule

`default_nettype wire

// ==== fb_config.sv ====
// registered framebuffer base, format, size, stride and video aspect ratio
`default_nettype none

`include "psx_loader_params.svh"

module fb_config (
	input  wire         clk_1x,
	input  wire         rst_n,

	// menu settings
	input  wire         color24,
	input  wire         vram_view,
	input  wire [1:0]   aspect_sel,

	// display geometry from the GPU
	input  wire [11:0]  display_width,
	input  wire [11:0]  display_height,
	input  wire [9:0]   display_offset_x,
	input  wire [8:0]   display_offset_y,

	// framebuffer setup
	output logic [31:0] fb_base,
	output logic [4:0]  fb_format,
	output logic [11:0] fb_width,
	output logic [11:0] fb_height,
	output logic [13:0] fb_stride,

	// aspect ratio for the scaler
	output logic [11:0] video_arx,
	output logic [11:0] video_ary
);

	// x offset in pixels of 2 bytes, y offset in lines of 2048 bytes
	wire [31:0] ofs_x_bytes = {21'd0, display_offset_x, 1'b0};
	wire [31:0] ofs_y_bytes = {12'd0, display_offset_y, 11'd0};
	wire [31:0] view_base   = `PSX_FB_ORIGIN + ofs_x_bytes + ofs_y_bytes;

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			fb_base   <= `PSX_FB_ORIGIN;
			fb_format <= `PSX_FB_FMT_16;
			fb_width  <= `PSX_VRAM_W;
			fb_height <= `PSX_VRAM_H;
			fb_stride <= `PSX_FB_STRIDE;
			video_arx <= 12'd4;
			video_ary <= 12'd3;
		end else begin
			// viewer shows all of VRAM from the origin
			fb_base   <= vram_view ? `PSX_FB_ORIGIN : view_base;
			fb_width  <= vram_view ? `PSX_VRAM_W : display_width;
			fb_height <= vram_view ? `PSX_VRAM_H : display_height;
			fb_format <= color24 ? `PSX_FB_FMT_24 : `PSX_FB_FMT_16;
			fb_stride <= `PSX_FB_STRIDE;

			// original ratio, 4:3 or 2:1 for the 1024x512 viewer
			if (aspect_sel == 2'd0) begin
				video_arx <= vram_view ? 12'd2 : 12'd4;
				video_ary <= vram_view ? 12'd1 : 12'd3;
			end else begin
				// other modes pass a small code with ary zero
				video_arx <= {10'd0, aspect_sel} - 12'd1;
				video_ary <= 12'd0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== psx_loader_top.sv ====
// top level of the loader, wiring control, packer, write port and fb setup
`default_nettype none

`include "psx_loader_params.svh"

module psx_loader_top (
	input  wire                      clk_1x,
	input  wire                      rst_n,

	// host download channel
	input  wire                      ioctl_download,
	input  wire [7:0]                ioctl_index,
	input  wire                      ioctl_wr,
	input  wire [`PSX_ADDR_W-1:0]    ioctl_addr,
	input  wire [`PSX_HALF_W-1:0]    ioctl_dout,
	output wire                      ioctl_wait,

	// system RAM write channel
	output wire                      mem_req,
	input  wire                      mem_ack,
	output wire [`PSX_ADDR_W-1:0]    mem_addr,
	output wire [`PSX_WORD_W-1:0]    mem_data,

	// core control
	output wire                      load_exe,
	output wire                      exe_loaded,
	output wire                      core_reset,

	// display settings and geometry
	input  wire                      color24,
	input  wire                      vram_view,
	input  wire [1:0]                aspect_sel,
	input  wire [11:0]               display_width,
	input  wire [11:0]               display_height,
	input  wire [9:0]                display_offset_x,
	input  wire [8:0]                display_offset_y,

	// framebuffer and aspect outputs
	output wire [31:0]               fb_base,
	output wire [4:0]                fb_format,
	output wire [11:0]               fb_width,
	output wire [11:0]               fb_height,
	output wire [13:0]               fb_stride,
	output wire [11:0]               video_arx,
	output wire [11:0]               video_ary
);

	// ============================================================
	// download path
	// ============================================================

	psx_loader_pkg::dl_kind_e kind;
	wire                      half_wr;

	// packer to write port
	mem_wr_if u_wr_if ();

	loader_ctrl u_ctrl (
		.clk_1x         (clk_1x),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.kind           (kind),
		.half_wr        (half_wr),
		.load_exe       (load_exe),
		.exe_loaded     (exe_loaded),
		.core_reset     (core_reset)
	);

	word_packer u_packer (
		.clk_1x     (clk_1x),
		.rst_n      (rst_n),
		.kind       (kind),
		.half_wr    (half_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout),
		.wr         (u_wr_if.packer)
	);

	mem_write_port u_wr_port (
		.clk_1x     (clk_1x),
		.rst_n      (rst_n),
		.wr         (u_wr_if.port),
		.mem_req    (mem_req),
		.mem_ack    (mem_ack),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.ioctl_wait (ioctl_wait)
	);

	// ============================================================
	// display setup
	// ============================================================

	fb_config u_fb (
		.clk_1x           (clk_1x),
		.rst_n            (rst_n),
		.color24          (color24),
		.vram_view        (vram_view),
		.aspect_sel       (aspect_sel),
		.display_width    (display_width),
		.display_height   (display_height),
		.display_offset_x (display_offset_x),
		.display_offset_y (display_offset_y),
		.fb_base          (fb_base),
		.fb_format        (fb_format),
		.fb_width         (fb_width),
		.fb_height        (fb_height),
		.fb_stride        (fb_stride),
		.video_arx        (video_arx),
		.video_ary        (video_ary)
	);

endmodule

`default_nettype wire

// ==== tb_psx_loader.sv ====
// testbench for psx_loader_top with clock, reset, host driver, RAM model and assertions
`default_nettype none

`include "psx_loader_params.svh"

module tb_psx_loader;

	logic                   clk_1x;
	logic                   rst_n;
	logic                   ioctl_download;
	logic [7:0]             ioctl_index;
	logic                   ioctl_wr;
	logic [`PSX_ADDR_W-1:0] ioctl_addr;
	logic [`PSX_HALF_W-1:0] ioctl_dout;
	logic                   mem_ack = 1'b0;
	logic                   color24;
	logic                   vram_view;
	logic [1:0]             aspect_sel;
	logic [11:0]            display_width;
	logic [11:0]            display_height;
	logic [9:0]             display_offset_x;
	logic [8:0]             display_offset_y;

	wire                    ioctl_wait;
	wire                    mem_req;
	wire [`PSX_ADDR_W-1:0]  mem_addr;
	wire [`PSX_WORD_W-1:0]  mem_data;
	wire                    load_exe;
	wire                    exe_loaded;
	wire                    core_reset;
	wire [31:0]             fb_base;
	wire [4:0]              fb_format;
	wire [11:0]             fb_width;
	wire [11:0]             fb_height;
	wire [13:0]             fb_stride;
	wire [11:0]             video_arx;
	wire [11:0]             video_ary;

	// expected RAM word of the current download word
	logic [`PSX_ADDR_W-1:0] exp_addr;
	logic [`PSX_WORD_W-1:0] exp_data;
	// expected framebuffer outputs, one cycle behind the settings
	logic [31:0]            exp_base;
	logic [4:0]             exp_format;
	logic [11:0]            exp_width;
	logic [11:0]            exp_height;
	logic [11:0]            exp_arx;
	logic [11:0]            exp_ary;
	logic                   dl_q;
	logic                   out_of_reset;

	// RAM model state and write count
	int                     ack_delay;
	int                     ram_writes;

	int                     exp_writes;
	int                     load_pulses;
	int                     value_errors;
	int                     protocol_errors;
	int                     timeouts;
	logic [7:0]             exe_sel;
	int                     i;

	// executables are every index but bios and cheats
	wire exe_index = (ioctl_index != 8'd0) && (ioctl_index != 8'hff);

	psx_loader_top u_dut (.*);

	initial begin
		clk_1x = 1'b0;
		forever #10 clk_1x = ~clk_1x;
	end

	// ============================================================
	// reporting
	// ============================================================

	task automatic value_mismatch(input string name, input logic [31:0] expv,
		input logic [31:0] actv);
		value_errors++;
		$display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expv, actv);
	endtask

	task automatic protocol_error(input string what);
		protocol_errors++;
		$display("protocol error at %0t: %s", $time, what);
	endtask

	task automatic finish_run();
		$display("errors: %0d value, %0d protocol, %0d timeout",
			value_errors, protocol_errors, timeouts);
		if (value_errors + protocol_errors + timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("timeout at %0t: %s", $time, what);
	endtask

	// ============================================================
	// host side
	// ============================================================

	// request must show up, then the wait flag must drop
	task automatic wait_write_done();
		int n;
		n = 0;
		while (!ioctl_wait && n < 8) begin
			@(negedge clk_1x);
			n++;
		end
		if (!ioctl_wait) report_timeout("no RAM request after an upper-half write");
		n = 0;
		while (ioctl_wait && n < 64) begin
			@(negedge clk_1x);
			n++;
		end
		if (ioctl_wait) report_timeout("ioctl_wait stayed high");
	endtask

	task automatic run_download(input logic [7:0] index, input int words);
		logic [`PSX_ADDR_W-1:0] addr;
		logic [15:0]            lo;
		logic [15:0]            hi;
		int                     w;
		// word aligned start in the first 4 KB
		addr = $urandom_range(0, 1023) * 4;
		@(negedge clk_1x);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		// kind registers one cycle late
		@(negedge clk_1x);
		for (w = 0; w < words; w++) begin
			lo       = $urandom;
			hi       = $urandom;
			exp_addr = ((index == 8'd0) ? `PSX_BIOS_BASE : `PSX_EXE_BASE) + addr;
			exp_data = {hi, lo};
			ioctl_addr = addr;
			ioctl_dout = lo;
			ioctl_wr   = 1'b1;
			@(negedge clk_1x);
			ioctl_addr = addr + 2;
			ioctl_dout = hi;
			@(negedge clk_1x);
			ioctl_wr = 1'b0;
			if (index != 8'hff) begin
				exp_writes++;
				wait_write_done();
			end else begin
				@(negedge clk_1x);
			end
			addr = addr + 4;
		end
		ioctl_download = 1'b0;
		// index held while the end of the download is decoded
		repeat (4) @(negedge clk_1x);
	endtask

	task automatic drive_display();
		color24          = $urandom;
		vram_view        = $urandom;
		aspect_sel       = $urandom;
		display_width    = $urandom_range(256, 1024);
		display_height   = $urandom_range(200, 512);
		display_offset_x = $urandom;
		display_offset_y = $urandom;
	endtask

	// ============================================================
	// RAM model, random ack delay of 0 to 7 cycles
	// ============================================================

	always @(negedge clk_1x) begin
		if (!rst_n) begin
			mem_ack   <= 1'b0;
			ack_delay <= $urandom_range(0, 7);
		end else if (mem_req && !mem_ack) begin
			if (ack_delay == 0) begin
				mem_ack    <= 1'b1;
				ram_writes <= ram_writes + 1;
				ack_delay  <= $urandom_range(0, 7);
			end else begin
				ack_delay <= ack_delay - 1;
			end
		end else if (!mem_req && mem_ack) begin
			mem_ack <= 1'b0;
		end
	end

	always @(negedge clk_1x) begin
		if (load_exe) load_pulses++;
	end

	// reference values from the fb rules
	always @(posedge clk_1x) begin
		exp_base   <= vram_view ? `PSX_FB_ORIGIN : `PSX_FB_ORIGIN +
			32'(display_offset_x) * 2 + 32'(display_offset_y) * 2048;
		exp_format <= color24 ? `PSX_FB_FMT_24 : `PSX_FB_FMT_16;
		exp_width  <= vram_view ? `PSX_VRAM_W : display_width;
		exp_height <= vram_view ? `PSX_VRAM_H : display_height;
		exp_arx    <= (aspect_sel == 2'd0) ? (vram_view ? 12'd2 : 12'd4) :
			12'(aspect_sel) - 12'd1;
		exp_ary    <= (aspect_sel == 2'd0) ? (vram_view ? 12'd1 : 12'd3) : 12'd0;
		dl_q       <= ioctl_download;
	end

	always @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) out_of_reset <= 1'b0;
		else out_of_reset <= 1'b1;
	end

	// ============================================================
	// assertions
	// ============================================================

	// write path, address and data held for the whole request
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		ioctl_wr && ioctl_addr[1] && ioctl_download && ioctl_index != 8'hff
		|-> ##2 $rose(mem_req))
		else protocol_error("mem_req not two cycles after upper half");
	assert property (@(posedge clk_1x) disable iff (!rst_n) mem_req |-> mem_addr == exp_addr)
		else value_mismatch("mem_addr", $sampled(exp_addr), $sampled(mem_addr));
	assert property (@(posedge clk_1x) disable iff (!rst_n) mem_req |-> mem_data == exp_data)
		else value_mismatch("mem_data", $sampled(exp_data), $sampled(mem_data));
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		$rose(mem_req) |-> ioctl_index != 8'hff)
		else protocol_error("RAM request during an index 255 download");

	// four-phase handshake and back-pressure
	assert property (@(posedge clk_1x) disable iff (!rst_n) $fell(mem_req) |-> $past(mem_ack))
		else protocol_error("mem_req fell before mem_ack was high");
	assert property (@(posedge clk_1x) disable iff (!rst_n) $rose(mem_req) |-> !$past(mem_ack))
		else protocol_error("mem_req rose while mem_ack was high");
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		$rose(mem_req) |-> $rose(ioctl_wait))
		else protocol_error("ioctl_wait did not rise with mem_req");
	assert property (@(posedge clk_1x) disable iff (!rst_n) mem_ack |-> ioctl_wait)
		else protocol_error("ioctl_wait low while mem_ack was high");
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		$fell(ioctl_wait) |-> !$past(mem_ack))
		else protocol_error("ioctl_wait fell before mem_ack fell");
	assert property (@(posedge clk_1x) disable iff (!rst_n) ioctl_wr |-> !ioctl_wait)
		else protocol_error("host wrote while ioctl_wait was high");

	// load pulse and loaded flag
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		$fell(ioctl_download) && exe_index
		|-> !load_exe ##1 !load_exe ##1 load_exe ##1 !load_exe)
		else protocol_error("load_exe missing or not one cycle wide after an executable");
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		load_exe |-> exe_index && !$past(ioctl_download, 2) && $past(ioctl_download, 3))
		else protocol_error("load_exe pulse without an executable end");
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		$rose(ioctl_download) && exe_index |=> exe_loaded)
		else value_mismatch("exe_loaded", 1, $sampled(exe_loaded));
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		$rose(exe_loaded) |-> $past(ioctl_download) && exe_index)
		else protocol_error("exe_loaded set without an executable download");
	assert property (@(posedge clk_1x) disable iff (!rst_n) !$fell(exe_loaded))
		else value_mismatch("exe_loaded", 1, $sampled(exe_loaded));

	// core reset
	assert property (@(posedge clk_1x) !rst_n |-> core_reset)
		else value_mismatch("core_reset", 1, $sampled(core_reset));
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		out_of_reset |-> core_reset == dl_q)
		else value_mismatch("core_reset", $sampled(dl_q), $sampled(core_reset));

	// framebuffer and aspect ratio
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		out_of_reset |-> fb_base == exp_base)
		else value_mismatch("fb_base", $sampled(exp_base), $sampled(fb_base));
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		out_of_reset |-> fb_format == exp_format)
		else value_mismatch("fb_format", $sampled(exp_format), $sampled(fb_format));
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		out_of_reset |-> fb_width == exp_width)
		else value_mismatch("fb_width", $sampled(exp_width), $sampled(fb_width));
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		out_of_reset |-> fb_height == exp_height)
		else value_mismatch("fb_height", $sampled(exp_height), $sampled(fb_height));
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		out_of_reset |-> fb_stride == `PSX_FB_STRIDE)
		else value_mismatch("fb_stride", `PSX_FB_STRIDE, $sampled(fb_stride));
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		out_of_reset |-> video_arx == exp_arx)
		else value_mismatch("video_arx", $sampled(exp_arx), $sampled(video_arx));
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		out_of_reset |-> video_ary == exp_ary)
		else value_mismatch("video_ary", $sampled(exp_ary), $sampled(video_ary));

	// ============================================================
	// stimulus
	// ============================================================

	initial begin
		void'($urandom(32'h7e7f_7749));
		rst_n          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		drive_display();
		// falling reset edge so the async reset fires
		#1 rst_n = 1'b0;
		repeat (4) @(posedge clk_1x);
		@(negedge clk_1x);
		rst_n = 1'b1;
		run_download(8'd0, 6);
		// cheat list while exe_loaded is still low, must be ignored
		run_download(8'hff, 4);
		drive_display();
		exe_sel = $urandom_range(1, 254);
		run_download(exe_sel, 6);
		run_download(8'd0, 3);
		for (i = 0; i < 24; i++) begin
			@(negedge clk_1x);
			drive_display();
		end
		repeat (2) @(negedge clk_1x);
		if (load_pulses != 1) value_mismatch("load_exe pulse count", 1, load_pulses);
		if (exe_loaded !== 1'b1) value_mismatch("exe_loaded", 1, exe_loaded);
		if (ram_writes != exp_writes) begin
			value_mismatch("RAM write count", exp_writes, ram_writes);
		end
		finish_run();
	end

endmodule

`default_nettype wire

// ==== psx_loader.f ====
+incdir+.
psx_loader_pkg.sv
mem_wr_if.sv
loader_ctrl.sv
word_packer.sv
mem_write_port.sv
fb_config.sv
psx_loader_top.sv
tb_psx_loader.sv

// ==== Bender.yml ====
package:
  name: psx_loader

export_include_dirs:
  - .

sources:
  # design, in compile order
  - psx_loader_pkg.sv
  - mem_wr_if.sv
  - loader_ctrl.sv
  - word_packer.sv
  - mem_write_port.sv
  - fb_config.sv
  - psx_loader_top.sv
  # testbench
  - target: test
    files:
      - tb_psx_loader.sv
